// File: Bender.yml
package:
  name: rv32e_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv32e_pkg.sv
      - logic/issue_if.sv
      - logic/result_if.sv
      - logic/bypass_if.sv
      - logic/rv32e_regfile.sv
      - logic/rv32e_decode.sv
      - logic/rv32e_execute.sv
      - logic/rv32e_memwb.sv
      - logic/rv32e_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_rv32e_core.sv

// File: logic/bypass_if.sv
// ==========================================================================
// MEM/WB and writeback registers fed back to forwarding and register file
// ==========================================================================
`timescale 1ns/1ps

interface bypass_if;
    import rv32e_pkg::*;

    reg_addr_t mw_rd;
    logic      mw_we;
    word_t     mw_result;
    reg_addr_t wb_rd;         // One stage past the register file write
    logic      wb_we;
    word_t     wb_result;

    modport memory (output mw_rd, mw_we, mw_result, wb_rd, wb_we, wb_result);
    modport execute (input mw_rd, mw_we, mw_result, wb_rd, wb_we, wb_result);
    modport regfile (input mw_rd, mw_we, mw_result);
endinterface

// File: logic/issue_if.sv
// ==========================================================================
// ID/EX register contents handed from decode to execute
// ==========================================================================
`timescale 1ns/1ps

interface issue_if;
    import rv32e_pkg::*;

    word_t     pc;
    reg_addr_t rs1_addr;      // Zero when the source is unused
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    reg_addr_t rd;
    alu_op_t   alu_op;
    logic      a_is_pc;
    logic      a_is_zero;
    logic      b_is_imm;
    logic      reg_we;
    logic      mem_we;
    logic      mem_re;

    modport decode (output pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd, alu_op,
                    a_is_pc, a_is_zero, b_is_imm, reg_we, mem_we, mem_re);
    modport execute (input pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd, alu_op,
                     a_is_pc, a_is_zero, b_is_imm, reg_we, mem_we, mem_re);
endinterface

// File: logic/result_if.sv
// ==========================================================================
// EX/MEM register contents handed from execute to the memory stage
// ==========================================================================
`timescale 1ns/1ps

interface result_if;
    import rv32e_pkg::*;

    word_t     result;        // ALU value, also the load/store address
    word_t     store_data;
    reg_addr_t rd;
    logic      reg_we;
    logic      mem_we;
    logic      mem_re;

    modport execute (output result, store_data, rd, reg_we, mem_we, mem_re);
    modport memory (input result, store_data, rd, reg_we, mem_we, mem_re);
endinterface

// File: logic/rv32e_core.sv
// ==========================================================================
// RV32E five-stage integer pipeline with plain instruction and data ports
// ==========================================================================
`timescale 1ns/1ps
`include "rv32e_params.svh"

module rv32e_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] instr_data_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    output logic [`XLEN-1:0] instr_addr_o,
    output logic [`XLEN-1:0] mem_addr_o,
    output logic [`XLEN-1:0] mem_wdata_o,
    output logic             mem_we_o,
    output logic             mem_re_o
);

    issue_if  issue ();   // ID/EX
    result_if res ();     // EX/MEM
    bypass_if byp ();     // MEM/WB and WB

    rv32e_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_data_i (instr_data_i),
        .instr_addr_o (instr_addr_o),
        .issue        (issue),
        .bypass       (byp)
    );

    rv32e_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .res   (res),
        .byp   (byp)
    );

    rv32e_memwb u_memwb (
        .clk         (clk),
        .rst_n       (rst_n),
        .res         (res),
        .byp         (byp),
        .mem_rdata_i (mem_rdata_i),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_we_o    (mem_we_o),
        .mem_re_o    (mem_re_o)
    );

endmodule

// File: logic/rv32e_decode.sv
// ==========================================================================
// Fetch and decode with PC, fetch register, field decode, stall and ID/EX
// ==========================================================================
`timescale 1ns/1ps
`include "rv32e_params.svh"

module rv32e_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  rv32e_pkg::word_t instr_data_i,
    output rv32e_pkg::word_t instr_addr_o,
    issue_if.decode          issue,
    bypass_if.regfile        bypass
);
    import rv32e_pkg::*;

    word_t     pc;
    word_t     fetch_pc;
    instr_u    fetch_instr;
    logic      stall;
    reg_addr_t rs1_sel;
    reg_addr_t rs2_sel;
    reg_addr_t rd_sel;
    logic      uses_rs1;
    logic      uses_rs2;
    word_t     imm;
    alu_op_t   alu_op;
    logic      a_is_pc;
    logic      a_is_zero;
    logic      b_is_imm;
    logic      reg_we;
    logic      mem_we;
    logic      mem_re;
    word_t     rf_rs1;
    word_t     rf_rs2;

    assign instr_addr_o = pc;

    always_comb begin
        imm       = '0;
        alu_op    = `ALU_ADD;   // Address and upper-immediate forms all add
        a_is_pc   = 1'b0;
        a_is_zero = 1'b0;
        b_is_imm  = 1'b0;
        reg_we    = 1'b0;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (fetch_instr.r.opcode)
            `OP_REG: begin
                alu_op   = {fetch_instr.r.funct7[5], fetch_instr.r.funct3};
                reg_we   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            `OP_IMM: begin
                imm      = {{(`XLEN-12){fetch_instr.i.imm12[11]}}, fetch_instr.i.imm12};
                // Only right shifts take bit 30 as the variant select
                alu_op   = (fetch_instr.i.funct3 == 3'b101) ?
                           {fetch_instr.i.imm12[10], 3'b101} : {1'b0, fetch_instr.i.funct3};
                b_is_imm = 1'b1;
                reg_we   = 1'b1;
                uses_rs1 = 1'b1;
            end
            `OP_LOAD: begin   // Every width handled as LW
                imm      = {{(`XLEN-12){fetch_instr.i.imm12[11]}}, fetch_instr.i.imm12};
                b_is_imm = 1'b1;
                reg_we   = 1'b1;
                mem_re   = 1'b1;
                uses_rs1 = 1'b1;
            end
            `OP_STORE: begin
                imm      = {{(`XLEN-12){fetch_instr.s.imm_hi[6]}},
                            fetch_instr.s.imm_hi, fetch_instr.s.imm_lo};
                b_is_imm = 1'b1;
                mem_we   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;      // Store data
            end
            `OP_LUI: begin
                imm       = {fetch_instr.u.imm20, 12'b0};
                a_is_zero = 1'b1;
                b_is_imm  = 1'b1;
                reg_we    = 1'b1;
            end
            `OP_AUIPC: begin
                imm      = {fetch_instr.u.imm20, 12'b0};
                a_is_pc  = 1'b1;
                b_is_imm = 1'b1;
                reg_we   = 1'b1;
            end
            default: ;            // SYSTEM, FENCE, unknown retire as no-ops
        endcase
    end

    assign rs1_sel = uses_rs1 ? fetch_instr.r.rs1[`REG_AW-1:0] : '0;
    assign rs2_sel = uses_rs2 ? fetch_instr.r.rs2[`REG_AW-1:0] : '0;
    assign rd_sel  = reg_we ? fetch_instr.u.rd[`REG_AW-1:0] : '0;

    // Load in ID/EX feeding the instruction in the fetch register
    assign stall = issue.mem_re && (issue.rd != '0) &&
                   ((rs1_sel == issue.rd) || (rs2_sel == issue.rd));

    rv32e_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_sel),
        .rs2_addr_i (rs2_sel),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2),
        .wr         (bypass)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= `RESET_PC;
            fetch_instr <= `NOP_INSTR;
        end else if (!stall) begin
            pc          <= pc + 32'd4;
            fetch_instr <= instr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) fetch_pc <= pc;
    end

    // ID/EX control with a bubble on stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue.rs1_addr  <= '0;
            issue.rs2_addr  <= '0;
            issue.rd        <= '0;
            issue.alu_op    <= `ALU_ADD;
            issue.a_is_pc   <= 1'b0;
            issue.a_is_zero <= 1'b0;
            issue.b_is_imm  <= 1'b0;
            issue.reg_we    <= 1'b0;
            issue.mem_we    <= 1'b0;
            issue.mem_re    <= 1'b0;
        end else begin
            issue.rs1_addr  <= stall ? '0 : rs1_sel;
            issue.rs2_addr  <= stall ? '0 : rs2_sel;
            issue.rd        <= stall ? '0 : rd_sel;
            issue.alu_op    <= stall ? `ALU_ADD : alu_op;
            issue.a_is_pc   <= stall ? 1'b0 : a_is_pc;
            issue.a_is_zero <= stall ? 1'b0 : a_is_zero;
            issue.b_is_imm  <= stall ? 1'b0 : b_is_imm;
            issue.reg_we    <= stall ? 1'b0 : reg_we;
            issue.mem_we    <= stall ? 1'b0 : mem_we;
            issue.mem_re    <= stall ? 1'b0 : mem_re;
        end
    end

    always_ff @(posedge clk) begin
        issue.pc       <= fetch_pc;
        issue.rs1_data <= rf_rs1;
        issue.rs2_data <= rf_rs2;
        issue.imm      <= imm;
    end

    // The bubble behind a stalled load can never stall again
    a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall);

endmodule

// File: logic/rv32e_execute.sv
// ==========================================================================
// Execute stage with three-source forwarding, operand select, ALU and EX/MEM
// ==========================================================================
`timescale 1ns/1ps
`include "rv32e_params.svh"

module rv32e_execute (
    input  logic      clk,
    input  logic      rst_n,
    issue_if.execute  issue,
    result_if.execute res,
    bypass_if.execute byp
);
    import rv32e_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t alu_y;
    logic  ex_hit;

    // Youngest producer wins and x0 is never forwarded
    function automatic word_t bypass_sel(input reg_addr_t src, input word_t rf_val);
        word_t val;
        val = rf_val;
        if (src != '0) begin
            if (res.reg_we && (res.rd == src)) val = res.result;
            else if (byp.mw_we && (byp.mw_rd == src)) val = byp.mw_result;
            else if (byp.wb_we && (byp.wb_rd == src)) val = byp.wb_result;
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = bypass_sel(issue.rs1_addr, issue.rs1_data);
        rs2_val = bypass_sel(issue.rs2_addr, issue.rs2_data);
    end

    assign op_a = issue.a_is_pc ? issue.pc : (issue.a_is_zero ? '0 : rs1_val);
    assign op_b = issue.b_is_imm ? issue.imm : rs2_val;

    always_comb begin
        case (issue.alu_op)
            `ALU_SUB:  alu_y = op_a - op_b;
            `ALU_SLL:  alu_y = op_a << op_b[4:0];
            `ALU_SLT:  alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU: alu_y = {31'b0, op_a < op_b};
            `ALU_XOR:  alu_y = op_a ^ op_b;
            `ALU_SRL:  alu_y = op_a >> op_b[4:0];
            `ALU_SRA:  alu_y = $signed(op_a) >>> op_b[4:0];
            `ALU_OR:   alu_y = op_a | op_b;
            `ALU_AND:  alu_y = op_a & op_b;
            default:   alu_y = op_a + op_b;   // ADD and address generation
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res.rd     <= '0;
            res.reg_we <= 1'b0;
            res.mem_we <= 1'b0;
            res.mem_re <= 1'b0;
        end else begin
            res.rd     <= issue.rd;
            res.reg_we <= issue.reg_we;
            res.mem_we <= issue.mem_we;
            res.mem_re <= issue.mem_re;
        end
    end

    always_ff @(posedge clk) begin
        res.result     <= alu_y;
        res.store_data <= rs2_val;    // Store data after forwarding
    end

    // Decode's load-use stall keeps loads out of the EX/MEM bypass
    assign ex_hit = res.reg_we && (res.rd != '0) &&
                    ((res.rd == issue.rs1_addr) || (res.rd == issue.rs2_addr));

    a_no_load_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        ex_hit |-> !res.mem_re);

endmodule

// File: logic/rv32e_memwb.sv
// ==========================================================================
// Memory and writeback: data port, result select, MEM/WB and WB registers
// ==========================================================================
`timescale 1ns/1ps
`include "rv32e_params.svh"

module rv32e_memwb (
    input  logic             clk,
    input  logic             rst_n,
    result_if.memory         res,
    bypass_if.memory         byp,
    input  rv32e_pkg::word_t mem_rdata_i,
    output rv32e_pkg::word_t mem_addr_o,
    output rv32e_pkg::word_t mem_wdata_o,
    output logic             mem_we_o,
    output logic             mem_re_o
);
    import rv32e_pkg::*;

    word_t wb_val;

    // Memory answers in the same cycle
    assign mem_addr_o  = res.result;
    assign mem_wdata_o = res.store_data;
    assign mem_we_o    = res.mem_we;
    assign mem_re_o    = res.mem_re;

    assign wb_val = res.mem_re ? mem_rdata_i : res.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byp.mw_rd <= '0;
            byp.mw_we <= 1'b0;
            byp.wb_rd <= '0;
            byp.wb_we <= 1'b0;
        end else begin
            byp.mw_rd <= res.rd;
            byp.mw_we <= res.reg_we;
            byp.wb_rd <= byp.mw_rd;   // Covers the register file write cycle
            byp.wb_we <= byp.mw_we;
        end
    end

    always_ff @(posedge clk) begin
        byp.mw_result <= wb_val;
        byp.wb_result <= byp.mw_result;
    end

endmodule

// File: logic/rv32e_params.svh
// ==========================================================================
// RV32E core constants: widths, reset PC, opcodes and ALU operation codes
// ==========================================================================
`ifndef RV32E_PARAMS_SVH
`define RV32E_PARAMS_SVH

`define XLEN      32
`define REG_AW    4
`define NUM_REGS  16
`define RESET_PC  32'h8000_0000
`define NOP_INSTR 32'h0000_0013   // ADDI x0, x0, 0

`define OP_REG   7'b0110011
`define OP_IMM   7'b0010011
`define OP_LOAD  7'b0000011
`define OP_STORE 7'b0100011
`define OP_LUI   7'b0110111
`define OP_AUIPC 7'b0010111

// {funct7[5], funct3}
`define ALU_ADD  4'b0000
`define ALU_SUB  4'b1000
`define ALU_SLL  4'b0001
`define ALU_SLT  4'b0010
`define ALU_SLTU 4'b0011
`define ALU_XOR  4'b0100
`define ALU_SRL  4'b0101
`define ALU_SRA  4'b1101
`define ALU_OR   4'b0110
`define ALU_AND  4'b0111

`endif

// File: logic/rv32e_pkg.sv
// ==========================================================================
// RV32E core types: machine word, register index and instruction formats
// ==========================================================================
`include "rv32e_params.svh"

package rv32e_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [3:0]         alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One fetched word, four ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_u;

endpackage

// File: logic/rv32e_regfile.sv
// ==========================================================================
// Sixteen-entry register file, async read, write from MEM/WB, x0 held at zero
// ==========================================================================
`timescale 1ns/1ps
`include "rv32e_params.svh"

module rv32e_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs1_addr_i,
    input  logic [`REG_AW-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]   rs1_data_o,
    output logic [`XLEN-1:0]   rs2_data_o,
    bypass_if.regfile          wr
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;    // Architectural state starts cleared
            end
        end else if (wr.mw_we && (wr.mw_rd != '0)) begin
            regs[wr.mw_rd] <= wr.mw_result;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // x0 is never written after reset
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1_addr_i == '0) |-> (rs1_data_o == '0)) and
        ((rs2_addr_i == '0) |-> (rs2_data_o == '0)));

endmodule

// File: sim.f
+incdir+logic
logic/rv32e_pkg.sv
logic/issue_if.sv
logic/result_if.sv
logic/bypass_if.sv
logic/rv32e_regfile.sv
logic/rv32e_decode.sv
logic/rv32e_execute.sv
logic/rv32e_memwb.sv
logic/rv32e_core.sv
tests/tb_rv32e_core.sv

// File: tests/tb_rv32e_core.sv
// ==========================================================================
// Testbench for the RV32E pipeline with random program and in-order ISA model
// ==========================================================================
`timescale 1ns/1ps
`include "rv32e_params.svh"

module tb_rv32e_core;

    localparam int RAND_LEN = 60;
    localparam int PROG_MAX = 80;
    localparam int TIMEOUT  = 2000;
    localparam int DRAIN    = 30;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_data_i;
    logic [31:0] mem_rdata_i;
    logic [31:0] instr_addr_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_wdata_o;
    logic        mem_we_o;
    logic        mem_re_o;

    integer      seed = 88;
    int          prog_len;
    int          store_idx;
    int          cycles;
    logic [31:0] prog [PROG_MAX];
    logic [31:0] dmem [64];      // Data window seen by the DUT
    logic [31:0] ref_mem [64];   // Same window as seen by the model
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    rv32e_core UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_data_i (instr_data_i),
        .mem_rdata_i  (mem_rdata_i),
        .instr_addr_o (instr_addr_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (mem_we_o),
        .mem_re_o     (mem_re_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic logic [4:0] pick_source(input logic [4:0] recent);
        logic [4:0] r;
        r = rand_below(16);
        if (rand_below(2) == 0) begin
            r = recent;    // Consume the value just produced
        end
        return r;
    endfunction

    function automatic logic [31:0] r_type_word(input logic alt, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                                input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < prog_len) begin
            return prog[idx];
        end else begin
            return `NOP_INSTR;    // Past the end or address unknown
        end
    endfunction

    task automatic gen_program();
        logic [4:0]  recent;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          kind;
        recent = 5'd0;
        for (int k = 0; k < RAND_LEN; k++) begin
            kind = rand_below(10);
            rd   = rand_below(16);
            rs1  = pick_source(recent);
            rs2  = pick_source(recent);
            f3   = rand_below(8);
            imm  = $random(seed);
            case (kind)
                0, 1, 2: prog[k] = r_type_word((f3 == 0 || f3 == 5) && imm[0], rs2, rs1, f3, rd);
                3, 4: begin
                    if (f3 == 3'b001) begin
                        imm = {7'b0, imm[4:0]};
                    end else if (f3 == 3'b101) begin
                        imm = {1'b0, imm[10], 5'b0, imm[4:0]};    // SRLI or SRAI
                    end
                    prog[k] = i_type_word(imm, rs1, f3, rd, `OP_IMM);
                end
                5, 6: prog[k] = i_type_word({4'b0, imm[5:0], 2'b0}, rs1, 3'b010, rd, `OP_LOAD);
                7: prog[k] = s_type_word({4'b0, imm[5:0], 2'b0}, rs2, rs1);
                8: prog[k] = u_type_word($random(seed), rd, `OP_LUI);
                default: prog[k] = u_type_word($random(seed), rd, `OP_AUIPC);
            endcase
            if (kind != 7) begin
                recent = rd;
            end
        end
        // Dump x1..x15 so every register is observed
        for (int i = 1; i < 16; i++) begin
            imm = i * 4;
            rs2 = i;
            prog[RAND_LEN + i - 1] = s_type_word(imm, rs2, 5'd0);
        end
        prog_len = RAND_LEN + 15;
    endtask

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] y;
        case (f3)
            3'b000: y = alt ? a - b : a + b;
            3'b001: y = a << b[4:0];
            3'b010: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: y = (a < b) ? 32'd1 : 32'd0;
            3'b100: y = a ^ b;
            3'b101: begin
                if (alt) begin
                    y = $signed(a) >>> b[4:0];
                end else begin
                    y = a >> b[4:0];
                end
            end
            3'b110: y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // Runs the whole program in order and collects the expected stores
    task automatic run_model();
        logic [31:0] regs [16];
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        logic [31:0] addr;
        logic        wr;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int k = 0; k < prog_len; k++) begin
            w  = prog[k];
            pc = `RESET_PC + 4 * k;
            a  = regs[w[18:15]];
            b  = regs[w[23:20]];
            y  = '0;
            wr = 1'b1;
            case (w[6:0])
                `OP_REG: y = model_alu(w[14:12], w[30], a, b);
                `OP_IMM: y = model_alu(w[14:12], (w[14:12] == 3'b101) && w[30], a,
                                       {{20{w[31]}}, w[31:20]});
                `OP_LUI: y = {w[31:12], 12'b0};
                `OP_AUIPC: y = pc + {w[31:12], 12'b0};
                `OP_LOAD: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    y    = ref_mem[addr[7:2]];
                end
                `OP_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    ref_mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && (w[10:7] != 4'd0)) begin
                regs[w[10:7]] = y;
            end
        end
    endtask

    // Memories answer once the registered addresses have settled
    always begin
        @(posedge clk);
        #1;
        if (rst_n && mem_we_o) begin
            if (store_idx >= exp_addr.size()) begin
                $display("DUT issued a store beyond the %0d expected", exp_addr.size());
                fail_run();
            end else begin
                check_value("mem_addr_o", mem_addr_o, exp_addr[store_idx]);
                check_value("mem_wdata_o", mem_wdata_o, exp_data[store_idx]);
                dmem[mem_addr_o[7:2]] = mem_wdata_o;
                store_idx++;
            end
        end
        instr_data_i = fetch_word(instr_addr_o);
        mem_rdata_i  = mem_re_o ? dmem[mem_addr_o[7:2]] : 'x;   // Valid only for a load
    end

    initial begin
        rst_n        = 1'b0;
        instr_data_i = `NOP_INSTR;
        mem_rdata_i  = '0;
        store_idx    = 0;
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = fill_word(i * 4);
            ref_mem[i] = fill_word(i * 4);
        end
        gen_program();
        run_model();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("instr_addr_o", instr_addr_o, `RESET_PC);
        check_value("mem_we_o", mem_we_o, 32'd0);
        check_value("mem_re_o", mem_re_o, 32'd0);
        cycles = 0;
        while (store_idx < exp_addr.size()) begin
            if (cycles >= TIMEOUT) begin
                $display("Timed out with %0d of %0d stores seen", store_idx, exp_addr.size());
                fail_run();
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        repeat (DRAIN) @(posedge clk);    // Extra stores would show here
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
